//--- all.f
+incdir+tests
common/cpu_pkg.sv
src/alu.sv
pipeline/ir_dec_ctrl.sv
pipeline/registers.sv
pipeline/pipeline_unit.sv
tests/tb_pipeline_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipeline_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Result: FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_PROGS  = 5;
localparam int MAX_WORDS  = 64;
localparam int MAX_STORES = 24;

string prog_name [NUM_PROGS];
word_t prog_code [NUM_PROGS][MAX_WORDS];
int    prog_len  [NUM_PROGS];
word_t exp_addr  [NUM_PROGS][MAX_STORES];
word_t exp_data  [NUM_PROGS][MAX_STORES];
int    exp_count [NUM_PROGS];
int    cur = -1;

function automatic word_t reg_op(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                 logic [2:0] f3, reg_idx_t rd);
  instr_u u;
  u.r_fmt = '{f7, rs2, rs1, f3, rd, OP_REG};
  return u;
endfunction

// also used for loads and jalr
function automatic word_t imm_op(logic [6:0] op, logic [11:0] imm, reg_idx_t rs1,
                                 logic [2:0] f3, reg_idx_t rd);
  instr_u u;
  u.i_fmt = '{imm, rs1, f3, rd, op};
  return u;
endfunction

// sw rs2, imm(rs1)
function automatic word_t store_op(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
  instr_u u;
  u.s_fmt = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  return u;
endfunction

function automatic word_t branch_op(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [12:0] off);
  instr_u u;
  u.b_fmt = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  return u;
endfunction

function automatic word_t upper_op(logic [6:0] op, logic [19:0] imm, reg_idx_t rd);
  instr_u u;
  u.u_fmt = '{imm, rd, op};
  return u;
endfunction

function automatic word_t jal_op(reg_idx_t rd, logic [20:0] off);
  instr_u u;
  u.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  return u;
endfunction

task automatic start_program(string name);
  cur++;
  prog_name[cur] = name;
  prog_len[cur]  = 0;
  exp_count[cur] = 0;
endtask

task automatic emit(word_t w);
  prog_code[cur][prog_len[cur]] = w;
  prog_len[cur]++;
endtask

task automatic expect_store(word_t addr, word_t data);
  exp_addr[cur][exp_count[cur]] = addr;
  exp_data[cur][exp_count[cur]] = data;
  exp_count[cur]++;
endtask

// store rs to off(x0) and expect the value there
task automatic store_check(reg_idx_t rs, logic [11:0] off, word_t value);
  emit(store_op(rs, 5'd0, off));
  expect_store({20'd0, off}, value);
endtask

task automatic build_programs();
  logic [2:0]  br_f3  [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
  reg_idx_t    pair_a [3] = '{5'd1, 5'd1, 5'd2};
  reg_idx_t    pair_b [3] = '{5'd1, 5'd2, 5'd1};
  // x1 = -2, x2 = 3; pairs (x1,x1) (x1,x2) (x2,x1), six branches each
  logic [0:17] taken_tbl = 18'b100101_011001_010110;

  start_program("alu_forwarding");
  emit(imm_op(OP_IMM, 12'd5, 5'd0, 3'b000, 5'd1));
  emit(imm_op(OP_IMM, 12'hFFD, 5'd1, 3'b000, 5'd2));
  emit(reg_op(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
  emit(reg_op(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
  emit(reg_op(7'h00, 5'd2, 5'd3, 3'b001, 5'd5));
  emit(reg_op(7'h00, 5'd3, 5'd4, 3'b010, 5'd6));
  emit(imm_op(OP_IMM, 12'hFFF, 5'd1, 3'b100, 5'd7));
  emit(imm_op(OP_IMM, 12'h401, 5'd7, 3'b101, 5'd8));
  emit(imm_op(OP_IMM, 12'h01C, 5'd7, 3'b101, 5'd9));
  emit(reg_op(7'h00, 5'd7, 5'd1, 3'b011, 5'd10));
  emit(reg_op(7'h00, 5'd9, 5'd8, 3'b111, 5'd11));
  store_check(5'd11, 12'h100, 32'h0000000D);
  store_check(5'd3, 12'h104, 32'd7);
  store_check(5'd4, 12'h108, 32'd2);
  store_check(5'd5, 12'h10C, 32'd28);
  store_check(5'd6, 12'h110, 32'd1);
  store_check(5'd8, 12'h114, 32'hFFFFFFFD);
  store_check(5'd9, 12'h118, 32'h0000000F);
  store_check(5'd10, 12'h11C, 32'd1);
  emit(jal_op(5'd0, 21'd0));

  start_program("load_use");
  emit(imm_op(OP_IMM, 12'h123, 5'd0, 3'b000, 5'd1));
  store_check(5'd1, 12'h080, 32'h123);
  emit(imm_op(OP_LOAD, 12'h080, 5'd0, 3'b010, 5'd2));
  emit(reg_op(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
  store_check(5'd3, 12'h084, 32'h246);
  emit(imm_op(OP_LOAD, 12'h084, 5'd0, 3'b010, 5'd4));
  // loaded value used as store data
  store_check(5'd4, 12'h088, 32'h246);
  emit(jal_op(5'd0, 21'd0));

  start_program("branches");
  emit(imm_op(OP_IMM, 12'hFFE, 5'd0, 3'b000, 5'd1));
  emit(imm_op(OP_IMM, 12'd3, 5'd0, 3'b000, 5'd2));
  for (int n = 0; n < 18; n++) begin
    emit(imm_op(OP_IMM, 12'd1, 5'd3, 3'b000, 5'd3));
    emit(branch_op(br_f3[n % 6], pair_a[n / 6], pair_b[n / 6], 13'd8));
    emit(store_op(5'd3, 5'd0, 12'(32'h200 + 4 * n)));
    if (!taken_tbl[n]) begin
      expect_store(32'h200 + 4 * n, n + 1);
    end
  end
  emit(jal_op(5'd0, 21'd0));

  start_program("jump_upper");
  emit(upper_op(OP_LUI, 20'h12345, 5'd1));
  emit(upper_op(OP_AUIPC, 20'h00001, 5'd2));
  emit(jal_op(5'd3, 21'd12));
  emit(store_op(5'd1, 5'd0, 12'h3FC));
  emit(store_op(5'd1, 5'd0, 12'h3FC));
  store_check(5'd1, 12'h300, 32'h12345000);
  store_check(5'd2, 12'h304, 32'h00001004);
  store_check(5'd3, 12'h308, 32'h0000000C);
  emit(imm_op(OP_IMM, 12'h02C, 5'd0, 3'b000, 5'd5));
  // 0x2c + 5 is odd, bit 0 gets cleared
  emit(imm_op(OP_JALR, 12'h005, 5'd5, 3'b000, 5'd6));
  emit(store_op(5'd1, 5'd0, 12'h3FC));
  emit(store_op(5'd1, 5'd0, 12'h3FC));
  store_check(5'd6, 12'h30C, 32'h00000028);
  emit(jal_op(5'd0, 21'd0));

  start_program("x0_write");
  emit(imm_op(OP_IMM, 12'd7, 5'd0, 3'b000, 5'd0));
  emit(reg_op(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
  emit(upper_op(OP_LUI, 20'hFFFFF, 5'd0));
  emit(imm_op(OP_IMM, 12'd1, 5'd0, 3'b000, 5'd2));
  store_check(5'd0, 12'h400, 32'd0);
  store_check(5'd1, 12'h404, 32'd0);
  store_check(5'd2, 12'h408, 32'd1);
  emit(jal_op(5'd0, 21'd0));
endtask

`endif

//--- tests/tb_pipeline_unit.sv
`timescale 1ns/1ps

module tb_pipeline_unit import cpu_pkg::*; ();

  logic  clk;
  logic  rst;
  word_t instr;
  logic  instr_ready = 1'b0;
  word_t mem_read_data;
  logic  data_ready = 1'b0;
  logic  read_instr;
  word_t pc_addr;
  logic  mem_en;
  logic  mem_rw;
  word_t mem_addr;
  word_t mem_write_data;

  word_t imem [64];
  word_t dmem [512];
  int    errors = 0;
  int    hangs = 0;
  int    stores_seen = 0;
  int    run_cycles = 0;
  int    cur_prog = 0;
  logic  stall_mode = 1'b0;
  string test_name;

  `include "tb_programs.svh"

  pipeline_unit pipeline_unit_inst (
    .clk           (clk),
    .rst           (rst),
    .instr         (instr),
    .instr_ready   (instr_ready),
    .mem_read_data (mem_read_data),
    .data_ready    (data_ready),
    .read_instr    (read_instr),
    .pc_addr       (pc_addr),
    .mem_en        (mem_en),
    .mem_rw        (mem_rw),
    .mem_addr      (mem_addr),
    .mem_write_data(mem_write_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // rom and data memory answer combinationally
  assign instr         = imem[pc_addr[7:2]];
  assign mem_read_data = dmem[mem_addr[10:2]];

  always @(posedge clk) begin
    if (stall_mode) begin
      instr_ready <= ($urandom % 4) != 0;
      data_ready  <= ($urandom % 3) != 0;
    end else begin
      instr_ready <= 1'b1;
      data_ready  <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 512; i++) begin
        dmem[i] <= 32'hC0DE0000 ^ (i * 4);
      end
    end else if (mem_en && mem_rw) begin
      dmem[mem_addr[10:2]] <= mem_write_data;
    end
  end

  // store seen here is taken on the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      stores_seen = 0;
      run_cycles  = 0;
      if (read_instr !== 1'b0 || mem_en !== 1'b0 || mem_rw !== 1'b0) begin
        $display("ERR %s in reset read_instr mem_en mem_rw: expected 000 actual %b%b%b",
                 test_name, read_instr, mem_en, mem_rw);
        errors++;
      end
    end else begin
      run_cycles++;
      // fetch is running by the second cycle out of reset
      if (run_cycles == 2 && read_instr !== 1'b1) begin
        $display("ERR %s read_instr after reset: expected 1 actual %b",
                 test_name, read_instr);
        errors++;
      end
      // nothing is fetched while a load waits
      if (mem_en && !mem_rw && !data_ready && read_instr !== 1'b0) begin
        $display("ERR %s read_instr during load wait: expected 0 actual %b",
                 test_name, read_instr);
        errors++;
      end
      if (mem_en && mem_rw) begin
        if (stores_seen >= exp_count[cur_prog]) begin
          $display("%s: unexpected extra store of %h to address %h",
                   test_name, mem_write_data, mem_addr);
          errors++;
        end else begin
          if (mem_addr !== exp_addr[cur_prog][stores_seen]) begin
            $display("ERR %s store %0d addr: expected %h actual %h", test_name,
                     stores_seen, exp_addr[cur_prog][stores_seen], mem_addr);
            errors++;
          end
          if (mem_write_data !== exp_data[cur_prog][stores_seen]) begin
            $display("ERR %s store %0d data: expected %h actual %h", test_name,
                     stores_seen, exp_data[cur_prog][stores_seen], mem_write_data);
            errors++;
          end
        end
        stores_seen++;
      end
    end
  end

  task automatic run_program(int p, logic stalls);
    int cycles;
    int limit;

    @(posedge clk);
    rst <= 1'b1;
    cur_prog   = p;
    stall_mode <= stalls;
    if (stalls) begin
      test_name = {prog_name[p], "_stalled"};
    end else begin
      test_name = prog_name[p];
    end
    // unused rom words hold nops tagged with their own address
    for (int i = 0; i < MAX_WORDS; i++) begin
      if (i < prog_len[p]) begin
        imem[i] = prog_code[p][i];
      end else begin
        imem[i] = imm_op(OP_IMM, 12'(i * 4), 5'd0, 3'b000, 5'd0);
      end
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    limit  = 8 * prog_len[p] + 50;
    while (stores_seen < exp_count[p] && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (stores_seen < exp_count[p]) begin
      $display("%s hangs: only %0d of %0d stores after %0d cycles",
               test_name, stores_seen, exp_count[p], cycles);
      hangs++;
    end else begin
      // program now spins on its last jump, watch for stray stores
      repeat (20) @(posedge clk);
    end
  endtask

  initial begin
    rst <= 1'b1;
    void'($urandom(32'h2231));
    build_programs();
    for (int mode = 0; mode < 2; mode++) begin
      for (int p = 0; p < NUM_PROGS; p++) begin
        run_program(p, mode == 1);
      end
    end
    $display("store errors: %0d, hangs: %0d", errors, hangs);
    if (errors == 0 && hangs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- pipeline/pipeline_unit.sv
`timescale 1ns/1ps

module pipeline_unit import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  word_t instr,
  input  logic  instr_ready,
  input  word_t mem_read_data,
  input  logic  data_ready,
  output logic  read_instr,
  output word_t pc_addr,
  output logic  mem_en,
  output logic  mem_rw,
  output word_t mem_addr,
  output word_t mem_write_data
);

  word_t   pc_q;
  logic    run_q;
  fd_reg_t fd_q;
  de_reg_t de_q;
  de_reg_t de_d;
  em_reg_t em_q;
  mw_reg_t mw_q;

  reg_idx_t   dec_rs1, dec_rs2, dec_rd;
  word_t      dec_imm, rd_data1, rd_data2;
  logic [2:0] dec_func3;
  ctrl_t      dec_cs;

  logic  mem_wait, load_use, fetch_ok, taken, redirect;
  word_t fwd_a, fwd_b, alu_a, alu_b, alu_result, target;
  word_t em_fwd, wb_value;
  cmp_t  cmp;

  // hazards
  assign mem_wait = em_q.cs.l && !data_ready;
  assign load_use = de_q.cs.l && de_q.rd != '0 && fd_q.valid &&
                    (de_q.rd == dec_rs1 || de_q.rd == dec_rs2);

  // fetch
  assign read_instr = run_q && !mem_wait && !load_use;
  assign fetch_ok   = read_instr && instr_ready;
  assign pc_addr    = pc_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_q <= 1'b0;
      pc_q  <= RESET_PC;
    end else begin
      run_q <= 1'b1;
      if (!mem_wait && !load_use) begin
        if (redirect) begin
          pc_q <= target;
        end else if (fetch_ok) begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fd_q <= '0;
    end else if (!mem_wait && !load_use) begin
      fd_q.pc    <= pc_q;
      fd_q.instr <= instr;
      // the fetch in flight is on the wrong path after a redirect
      fd_q.valid <= fetch_ok && !redirect;
    end
  end

  // decode
  ir_dec_ctrl ir_dec (
    .ir   (fd_q.instr),
    .rs1  (dec_rs1),
    .rs2  (dec_rs2),
    .rd   (dec_rd),
    .imm  (dec_imm),
    .func3(dec_func3),
    .cs   (dec_cs)
  );

  registers reg_file (
    .clk     (clk),
    .rst     (rst),
    .w_en    (mw_q.w),
    .rd      (mw_q.rd),
    .w_data  (mw_q.value),
    .rs1     (dec_rs1),
    .rs2     (dec_rs2),
    .rd_data1(rd_data1),
    .rd_data2(rd_data2)
  );

  always_comb begin
    de_d.pc    = fd_q.pc;
    de_d.rs1   = dec_rs1;
    de_d.rs2   = dec_rs2;
    de_d.rd    = dec_rd;
    de_d.r1    = rd_data1;
    de_d.r2    = rd_data2;
    de_d.imm   = dec_imm;
    de_d.func3 = dec_func3;
    de_d.cs    = fd_q.valid ? dec_cs : '0;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      de_q <= '0;
    end else if (mem_wait) begin
      // writeback drains while held, keep operands current
      de_q.r1 <= fwd_a;
      de_q.r2 <= fwd_b;
    end else if (redirect || load_use) begin
      de_q <= '0;
    end else begin
      de_q <= de_d;
    end
  end

  // execute
  // memory stage value as seen by a younger instruction
  assign em_fwd = em_q.cs.j ? em_q.pc + 32'd4 : em_q.alu_result;

  // memory stage first, then writeback, then register file
  function automatic word_t forward(reg_idx_t rs, word_t reg_val, em_reg_t em,
                                    word_t em_val, mw_reg_t mw);
    if (em.cs.w && !em.cs.l && em.rd != '0 && em.rd == rs) begin
      return em_val;
    end
    if (mw.w && mw.rd != '0 && mw.rd == rs) begin
      return mw.value;
    end
    return reg_val;
  endfunction

  assign fwd_a = forward(de_q.rs1, de_q.r1, em_q, em_fwd, mw_q);
  assign fwd_b = forward(de_q.rs2, de_q.r2, em_q, em_fwd, mw_q);

  assign alu_a = de_q.cs.a_zero ? '0 : de_q.cs.a_pc ? de_q.pc : fwd_a;
  assign alu_b = de_q.cs.b_imm ? de_q.imm : fwd_b;

  alu alu_e (
    .alu_op    (de_q.cs.alu_op),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_result(alu_result),
    .cmp       (cmp)
  );

  always_comb begin
    case (de_q.func3)
      F3_BEQ:  taken = cmp.eq;
      F3_BNE:  taken = !cmp.eq;
      F3_BLT:  taken = cmp.lt;
      F3_BGE:  taken = !cmp.lt;
      F3_BLTU: taken = cmp.ltu;
      F3_BGEU: taken = !cmp.ltu;
      default: taken = 1'b0;
    endcase
  end

  assign redirect = de_q.cs.j || (de_q.cs.b && taken);
  // jal computes pc + imm in the alu as well
  assign target = de_q.cs.j ? {alu_result[XLEN-1:1], 1'b0} : de_q.pc + de_q.imm;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      em_q <= '0;
    end else if (!mem_wait) begin
      em_q.pc         <= de_q.pc;
      em_q.rd         <= de_q.rd;
      em_q.alu_result <= alu_result;
      em_q.store_data <= fwd_b;
      em_q.cs         <= de_q.cs;
    end
  end

  // memory
  assign mem_en         = em_q.cs.l || em_q.cs.s;
  assign mem_rw         = em_q.cs.s;
  assign mem_addr       = em_q.alu_result;
  assign mem_write_data = em_q.store_data;

  assign wb_value = em_q.cs.l ? mem_read_data : em_fwd;

  // writeback
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mw_q <= '0;
    end else if (mem_wait) begin
      mw_q <= '0;
    end else begin
      mw_q.rd    <= em_q.rd;
      mw_q.value <= wb_value;
      mw_q.w     <= em_q.cs.w;
    end
  end

endmodule

//--- pipeline/registers.sv
`timescale 1ns/1ps

module registers import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     w_en,
  input  reg_idx_t rd,
  input  word_t    w_data,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rd_data1,
  output word_t    rd_data2
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && rd != '0) begin
      regs[rd] <= w_data;
    end
  end

  // same-cycle write shows through
  assign rd_data1 = (rs1 == '0) ? '0 : (w_en && rd == rs1) ? w_data : regs[rs1];
  assign rd_data2 = (rs2 == '0) ? '0 : (w_en && rd == rs2) ? w_data : regs[rs2];

endmodule

//--- pipeline/ir_dec_ctrl.sv
`timescale 1ns/1ps

module ir_dec_ctrl import cpu_pkg::*; (
  input  instr_u     ir,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output word_t      imm,
  output logic [2:0] func3,
  output ctrl_t      cs
);

  // func3 to alu op, alt picks sub / sra
  function automatic alu_op_e arith_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  logic  shift_alt;

  assign rs1   = ir.r_fmt.rs1;
  assign rs2   = ir.r_fmt.rs2;
  assign rd    = ir.r_fmt.rd;
  assign func3 = ir.r_fmt.funct3;

  // sign-extended immediates per format
  assign imm_i = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
  assign imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
  assign imm_b = {{19{ir.b_fmt.imm12}}, ir.b_fmt.imm12, ir.b_fmt.imm11,
                  ir.b_fmt.imm10_5, ir.b_fmt.imm4_1, 1'b0};
  assign imm_u = {ir.u_fmt.imm, 12'b0};
  assign imm_j = {{11{ir.j_fmt.imm20}}, ir.j_fmt.imm20, ir.j_fmt.imm19_12,
                  ir.j_fmt.imm11, ir.j_fmt.imm10_1, 1'b0};

  // addi etc. carry imm bits in funct7, only shifts look at it
  assign shift_alt = (ir.i_fmt.funct3 == 3'b101) && ir.r_fmt.funct7[5];

  always_comb begin
    cs  = '0;
    imm = '0;
    case (ir.r_fmt.opcode)
      OP_LUI: begin
        imm = imm_u;
        cs.w = 1'b1; cs.a_zero = 1'b1; cs.b_imm = 1'b1; cs.alu_op = ALU_PASS_B;
      end
      OP_AUIPC: begin
        imm = imm_u;
        cs.w = 1'b1; cs.a_pc = 1'b1; cs.b_imm = 1'b1; cs.alu_op = ALU_ADD;
      end
      OP_JAL: begin
        imm = imm_j;
        cs.w = 1'b1; cs.j = 1'b1; cs.a_pc = 1'b1; cs.b_imm = 1'b1; cs.alu_op = ALU_ADD;
      end
      OP_JALR: begin
        imm = imm_i;
        cs.w = 1'b1; cs.j = 1'b1; cs.b_imm = 1'b1; cs.alu_op = ALU_ADD;
      end
      OP_BRANCH: begin
        imm = imm_b;
        cs.b = 1'b1; cs.alu_op = ALU_SUB;
      end
      OP_LOAD: begin
        imm = imm_i;
        cs.w = 1'b1; cs.l = 1'b1; cs.b_imm = 1'b1; cs.alu_op = ALU_ADD;
      end
      OP_STORE: begin
        imm = imm_s;
        cs.s = 1'b1; cs.b_imm = 1'b1; cs.alu_op = ALU_ADD;
      end
      OP_IMM: begin
        imm = imm_i;
        cs.w = 1'b1; cs.b_imm = 1'b1;
        cs.alu_op = arith_op(ir.i_fmt.funct3, shift_alt);
      end
      OP_REG: begin
        cs.w = 1'b1;
        cs.alu_op = arith_op(ir.r_fmt.funct3, ir.r_fmt.funct7[5]);
      end
      // anything else is a bubble
      default: cs = '0;
    endcase
  end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  alu_op_e alu_op,
  input  word_t   alu_a,
  input  word_t   alu_b,
  output word_t   alu_result,
  output cmp_t    cmp
);

  logic [4:0] shamt;

  assign shamt = alu_b[4:0];

  // flags for the branch decision
  assign cmp.eq  = (alu_a == alu_b);
  assign cmp.lt  = ($signed(alu_a) < $signed(alu_b));
  assign cmp.ltu = (alu_a < alu_b);

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_SLL:    alu_result = alu_a << shamt;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, cmp.lt};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, cmp.ltu};
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      ALU_SRL:    alu_result = alu_a >> shamt;
      ALU_SRA:    alu_result = word_t'($signed(alu_a) >>> shamt);
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

endmodule

//--- common/cpu_pkg.sv
package cpu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  localparam word_t RESET_PC = '0;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // one instruction word, six field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic    w;
    logic    l;
    logic    s;
    logic    j;
    logic    b;
    logic    a_pc;
    logic    a_zero;
    logic    b_imm;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic eq;
    logic lt;
    logic ltu;
  } cmp_t;

  typedef struct packed {
    word_t  pc;
    instr_u instr;
    logic   valid;
  } fd_reg_t;

  typedef struct packed {
    word_t      pc;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      r1;
    word_t      r2;
    word_t      imm;
    logic [2:0] func3;
    ctrl_t      cs;
  } de_reg_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    alu_result;
    word_t    store_data;
    ctrl_t    cs;
  } em_reg_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    value;
    logic     w;
  } mw_reg_t;

endpackage
